/* hw/dwc_pkg.sv */
// Shared widths and types for the 32-to-64 bit AXI write upsizer.
// Imported by the RTL stages and by the testbench reference model.
// The wide data word is a union so that it can be filled per byte or per lane.
package dwc_pkg;

  // Data path widths
  localparam int unsigned SlvDataWidth = 32;
  localparam int unsigned MstDataWidth = 64;
  localparam int unsigned SlvStrbWidth = SlvDataWidth / 8;
  localparam int unsigned MstStrbWidth = MstDataWidth / 8;

  // Largest AxSIZE code on each side
  localparam int unsigned SlvMaxSize = $clog2(SlvStrbWidth);
  localparam int unsigned MstMaxSize = $clog2(MstStrbWidth);

  localparam int unsigned LanesPerWord = MstDataWidth / SlvDataWidth;

  // AxCACHE bit that allows merging of narrow beats
  localparam int unsigned CacheModifiable = 1;

  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;
  typedef logic [3:0] cache_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // How the data stage treats the beats of one burst
  typedef enum logic [1:0] {
    MODE_PASS   = 2'b00,
    MODE_UPSIZE = 2'b01,
    MODE_ERROR  = 2'b10
  } mode_e;

  typedef union packed {
    logic [MstStrbWidth-1:0][7:0]              bytes;
    logic [LanesPerWord-1:0][SlvDataWidth-1:0] lanes;
  } wide_word_u;

  typedef logic [MstStrbWidth-1:0] mst_strb_t;

endpackage

/* hw/dwc_aw_decode.sv */
// Address stage of the write upsizer.
// Sorts each slave-side write burst into upsize, passthrough or error,
// computes the master-side length and size, and registers the master AW
// and the burst context for the data stage in one cycle.

`timescale 1ns/100ps

module dwc_aw_decode
  import dwc_pkg::*;
#(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 aw_valid_i,
  input  logic [AddrWidth-1:0] aw_addr_i,
  input  len_t                 aw_len_i,
  input  size_t                aw_size_i,
  input  burst_e               aw_burst_i,
  input  cache_t               aw_cache_i,
  output logic                 mst_aw_valid_o,
  output logic [AddrWidth-1:0] mst_aw_addr_o,
  output len_t                 mst_aw_len_o,
  output size_t                mst_aw_size_o,
  output burst_e               mst_aw_burst_o,
  output logic                 err_o,
  output logic                 ctx_valid_o,
  output mode_e                ctx_mode_o,
  output logic [AddrWidth-1:0] ctx_addr_o,
  output len_t                 ctx_len_o,
  output size_t                ctx_size_o
);

  mode_e                mode;
  logic [AddrWidth-1:0] wide_mask;
  logic [AddrWidth-1:0] size_mask;
  logic [AddrWidth-1:0] start_addr;
  logic [AddrWidth-1:0] last_addr;
  logic [AddrWidth-1:0] end_addr;
  logic [AddrWidth-1:0] span;
  len_t                 up_len;

  logic aw_valid_q;
  logic err_q;
  logic ctx_valid_q;

  // Burst classification
  always_comb begin
    mode = MODE_PASS;
    case (aw_burst_i)
      BURST_INCR: begin
        // Single beats gain nothing from upsizing
        if (aw_cache_i[CacheModifiable] && (aw_len_i != '0)) begin
          mode = MODE_UPSIZE;
        end
      end
      BURST_WRAP, BURST_FIXED: begin
        if (aw_len_i != '0) begin
          mode = MODE_ERROR;
        end
      end
      // Reserved burst encoding
      default: mode = MODE_ERROR;
    endcase
  end

  // Wide-aligned first and last beat addresses give the wide beat count
  assign wide_mask  = {AddrWidth{1'b1}} << MstMaxSize;
  assign size_mask  = {AddrWidth{1'b1}} << aw_size_i;
  assign start_addr = aw_addr_i & wide_mask;
  assign last_addr  = (aw_addr_i & size_mask) + (AddrWidth'(aw_len_i) << aw_size_i);
  assign end_addr   = last_addr & wide_mask;
  assign span       = (end_addr - start_addr) >> MstMaxSize;
  assign up_len     = len_t'(span);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_valid_q  <= 1'b0;
      err_q       <= 1'b0;
      ctx_valid_q <= 1'b0;
    end else begin
      aw_valid_q  <= aw_valid_i && (mode != MODE_ERROR);
      err_q       <= aw_valid_i && (mode == MODE_ERROR);
      ctx_valid_q <= aw_valid_i;
    end
  end

  // Burst fields are only sampled with the address strobe
  always_ff @(posedge clk_i) begin
    if (aw_valid_i) begin
      mst_aw_addr_o  <= aw_addr_i;
      mst_aw_burst_o <= aw_burst_i;
      if (mode == MODE_UPSIZE) begin
        mst_aw_len_o  <= up_len;
        mst_aw_size_o <= size_t'(MstMaxSize);
      end else begin
        mst_aw_len_o  <= aw_len_i;
        mst_aw_size_o <= aw_size_i;
      end
      ctx_mode_o <= mode;
      ctx_addr_o <= aw_addr_i;
      ctx_len_o  <= aw_len_i;
      ctx_size_o <= aw_size_i;
    end
  end

  assign mst_aw_valid_o = aw_valid_q;
  assign err_o          = err_q;
  assign ctx_valid_o    = ctx_valid_q;

endmodule

/* hw/dwc_w_packer.sv */
// Data stage of the write upsizer.
// Steers each narrow beat into the byte lanes of the wide word, merges
// beats of an upsized burst and emits one wide beat per filled word.
// Beats of an error burst are counted and dropped.

`timescale 1ns/100ps

module dwc_w_packer
  import dwc_pkg::*;
#(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    ctx_valid_i,
  input  mode_e                   ctx_mode_i,
  input  logic [AddrWidth-1:0]    ctx_addr_i,
  input  len_t                    ctx_len_i,
  input  size_t                   ctx_size_i,
  input  logic                    w_valid_i,
  input  logic [SlvDataWidth-1:0] w_data_i,
  input  logic [SlvStrbWidth-1:0] w_strb_i,
  output logic                    mst_w_valid_o,
  output wide_word_u              mst_w_data_o,
  output mst_strb_t               mst_w_strb_o,
  output logic                    mst_w_last_o,
  output logic                    busy_o
);

  // Burst state
  logic                 active_q;
  mode_e                mode_q;
  logic [AddrWidth-1:0] addr_q;
  len_t                 left_q;
  size_t                size_q;

  // Partially filled wide word
  wide_word_u acc_q;
  mst_strb_t  acc_strb_q;

  logic out_valid_q;
  logic out_last_q;

  // The first beat may arrive together with the context
  mode_e                cur_mode;
  logic [AddrWidth-1:0] cur_addr;
  len_t                 cur_left;
  size_t                cur_size;

  logic                              beat_en;
  logic                              last_beat;
  logic                              crosses;
  logic                              full_beat;
  logic                              emit;
  logic [$clog2(LanesPerWord)-1:0]   lane;
  logic [AddrWidth-1:0]              next_addr;
  wide_word_u                        base;
  mst_strb_t                         base_strb;
  wide_word_u                        merged;
  mst_strb_t                         merged_strb;

  assign cur_mode = ctx_valid_i ? ctx_mode_i : mode_q;
  assign cur_addr = ctx_valid_i ? ctx_addr_i : addr_q;
  assign cur_left = ctx_valid_i ? ctx_len_i : left_q;
  assign cur_size = ctx_valid_i ? ctx_size_i : size_q;

  assign beat_en   = w_valid_i && (ctx_valid_i || active_q);
  assign last_beat = (cur_left == '0);
  assign lane      = cur_addr[SlvMaxSize +: $clog2(LanesPerWord)];
  assign full_beat = (cur_size == size_t'(SlvMaxSize)) && (cur_addr[SlvMaxSize-1:0] == '0);

  // Next beat address, aligned to the beat size
  assign next_addr = (cur_addr & ({AddrWidth{1'b1}} << cur_size)) +
                     (AddrWidth'(1) << cur_size);
  assign crosses   = next_addr[AddrWidth-1:MstMaxSize] != cur_addr[AddrWidth-1:MstMaxSize];

  // A new burst starts from an empty word
  assign base      = ctx_valid_i ? '0 : acc_q;
  assign base_strb = ctx_valid_i ? '0 : acc_strb_q;

  // Lane steering
  always_comb begin
    int unsigned mst_off;
    int unsigned lane_base;
    int unsigned beat_bytes;
    int unsigned nb;
    mst_off     = int'(cur_addr[MstMaxSize-1:0]);
    lane_base   = int'(lane) * SlvStrbWidth;
    beat_bytes  = 1 << cur_size;
    nb          = 0;
    merged      = base;
    merged_strb = base_strb;
    if (full_beat) begin
      merged.lanes[lane] = w_data_i;
      merged_strb[lane_base +: SlvStrbWidth] = w_strb_i;
    end else begin
      // Only the bytes of this beat that fall inside the addressed lane
      for (int unsigned b = 0; b < MstStrbWidth; b++) begin
        nb = b - lane_base;
        if ((b >= mst_off) && (b < lane_base + SlvStrbWidth) && (b - mst_off < beat_bytes)) begin
          merged.bytes[b] = w_data_i[8*nb +: 8];
          merged_strb[b]  = w_strb_i[nb];
        end
      end
    end
  end

  always_comb begin
    case (cur_mode)
      MODE_PASS:   emit = beat_en;
      // Flush once the word is full or the burst ends
      MODE_UPSIZE: emit = beat_en && (crosses || last_beat);
      default:     emit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q    <= 1'b0;
      mode_q      <= MODE_PASS;
      left_q      <= '0;
      out_valid_q <= 1'b0;
      out_last_q  <= 1'b0;
    end else begin
      out_valid_q <= emit;
      out_last_q  <= emit && last_beat;
      if (beat_en) begin
        active_q <= !last_beat;
        left_q   <= cur_left - len_t'(1);
      end else if (ctx_valid_i) begin
        active_q <= 1'b1;
        left_q   <= ctx_len_i;
      end
      if (ctx_valid_i) begin
        mode_q <= ctx_mode_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_en) begin
      addr_q     <= next_addr;
      acc_q      <= emit ? '0 : merged;
      acc_strb_q <= emit ? '0 : merged_strb;
    end else if (ctx_valid_i) begin
      addr_q     <= ctx_addr_i;
      acc_q      <= '0;
      acc_strb_q <= '0;
    end
    if (ctx_valid_i) begin
      size_q <= ctx_size_i;
    end
    if (emit) begin
      mst_w_data_o <= merged;
      mst_w_strb_o <= merged_strb;
    end
  end

  assign mst_w_valid_o = out_valid_q;
  assign mst_w_last_o  = out_last_q;
  // Held until the final wide beat has left the output register
  assign busy_o        = ctx_valid_i || active_q || out_valid_q;

endmodule

/* hw/dwc_upsizer_top.sv */
// Top level of the AXI write upsizer, 32-bit slave side to 64-bit master side.
// The address stage feeds a burst context into the data stage.
// Uses single-cycle valid strobes and no back-pressure.

`timescale 1ns/100ps

module dwc_upsizer_top
  import dwc_pkg::*;
#(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Slave side
  input  logic                    slv_aw_valid_i,
  input  logic [AddrWidth-1:0]    slv_aw_addr_i,
  input  len_t                    slv_aw_len_i,
  input  size_t                   slv_aw_size_i,
  input  burst_e                  slv_aw_burst_i,
  input  cache_t                  slv_aw_cache_i,
  input  logic                    slv_w_valid_i,
  input  logic [SlvDataWidth-1:0] slv_w_data_i,
  input  logic [SlvStrbWidth-1:0] slv_w_strb_i,
  // Master side
  output logic                    mst_aw_valid_o,
  output logic [AddrWidth-1:0]    mst_aw_addr_o,
  output len_t                    mst_aw_len_o,
  output size_t                   mst_aw_size_o,
  output burst_e                  mst_aw_burst_o,
  output logic                    mst_w_valid_o,
  output wide_word_u              mst_w_data_o,
  output mst_strb_t               mst_w_strb_o,
  output logic                    mst_w_last_o,
  output logic                    slv_err_o,
  output logic                    busy_o
);

  logic                 ctx_valid;
  mode_e                ctx_mode;
  logic [AddrWidth-1:0] ctx_addr;
  len_t                 ctx_len;
  size_t                ctx_size;

  dwc_aw_decode #(
    .AddrWidth(AddrWidth)
  ) dwc_aw_decode_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .aw_valid_i    (slv_aw_valid_i),
    .aw_addr_i     (slv_aw_addr_i),
    .aw_len_i      (slv_aw_len_i),
    .aw_size_i     (slv_aw_size_i),
    .aw_burst_i    (slv_aw_burst_i),
    .aw_cache_i    (slv_aw_cache_i),
    .mst_aw_valid_o(mst_aw_valid_o),
    .mst_aw_addr_o (mst_aw_addr_o),
    .mst_aw_len_o  (mst_aw_len_o),
    .mst_aw_size_o (mst_aw_size_o),
    .mst_aw_burst_o(mst_aw_burst_o),
    .err_o         (slv_err_o),
    .ctx_valid_o   (ctx_valid),
    .ctx_mode_o    (ctx_mode),
    .ctx_addr_o    (ctx_addr),
    .ctx_len_o     (ctx_len),
    .ctx_size_o    (ctx_size)
  );

  dwc_w_packer #(
    .AddrWidth(AddrWidth)
  ) dwc_w_packer_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ctx_valid_i  (ctx_valid),
    .ctx_mode_i   (ctx_mode),
    .ctx_addr_i   (ctx_addr),
    .ctx_len_i    (ctx_len),
    .ctx_size_i   (ctx_size),
    .w_valid_i    (slv_w_valid_i),
    .w_data_i     (slv_w_data_i),
    .w_strb_i     (slv_w_strb_i),
    .mst_w_valid_o(mst_w_valid_o),
    .mst_w_data_o (mst_w_data_o),
    .mst_w_strb_o (mst_w_strb_o),
    .mst_w_last_o (mst_w_last_o),
    .busy_o       (busy_o)
  );

endmodule

/* dv/dwc_upsizer_asserts.sv */
// Concurrent protocol assertions on the upsizer top level.
// Attached to every dwc_upsizer_top instance by the bind at the bottom.

`timescale 1ns/100ps

module dwc_upsizer_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic slv_aw_valid_i,
  input logic mst_aw_valid_i,
  input logic slv_err_i,
  input logic mst_w_valid_i,
  input logic mst_w_last_i,
  input logic busy_i
);

  // An error burst never reaches the master side
  a_err_excludes_aw: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(slv_err_i && mst_aw_valid_i))
    else $error("slv_err_o and mst_aw_valid_o pulsed in the same cycle");

  a_last_with_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_w_last_i |-> mst_w_valid_i)
    else $error("mst_w_last_o seen without mst_w_valid_o");

  a_valid_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_w_valid_i |-> busy_i)
    else $error("mst_w_valid_o seen while busy_o was low");

  // Master address is the registered slave address, one cycle later
  a_aw_after_slv: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_aw_valid_i |-> $past(slv_aw_valid_i))
    else $error("mst_aw_valid_o without a slave address one cycle before");

  a_slv_gets_response: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_aw_valid_i |=> (mst_aw_valid_i || slv_err_i))
    else $error("Slave address got neither a master address nor an error");

endmodule

bind dwc_upsizer_top dwc_upsizer_asserts dwc_upsizer_asserts_i (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .slv_aw_valid_i(slv_aw_valid_i),
  .mst_aw_valid_i(mst_aw_valid_o),
  .slv_err_i     (slv_err_o),
  .mst_w_valid_i (mst_w_valid_o),
  .mst_w_last_i  (mst_w_last_o),
  .busy_i        (busy_o)
);

/* dv/dwc_upsizer_tb.sv */
// Table-driven testbench for the 32-to-64 bit AXI write upsizer.
// Each table row sends one burst. A byte-lane model predicts the master AW,
// the wide beats and the error strobe, and a negedge monitor collects the DUT outputs.

`timescale 1ns/100ps

module dwc_upsizer_tb
  import dwc_pkg::*;
();

  localparam int unsigned AddrWidth = 32;
  localparam int NumTests = 6;
  localparam int TimeoutCycles = 16 + NumTests * 40;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    slv_aw_valid_i;
  logic [AddrWidth-1:0]    slv_aw_addr_i;
  len_t                    slv_aw_len_i;
  size_t                   slv_aw_size_i;
  burst_e                  slv_aw_burst_i;
  cache_t                  slv_aw_cache_i;
  logic                    slv_w_valid_i;
  logic [SlvDataWidth-1:0] slv_w_data_i;
  logic [SlvStrbWidth-1:0] slv_w_strb_i;
  logic                    mst_aw_valid_o;
  logic [AddrWidth-1:0]    mst_aw_addr_o;
  len_t                    mst_aw_len_o;
  size_t                   mst_aw_size_o;
  burst_e                  mst_aw_burst_o;
  logic                    mst_w_valid_o;
  wide_word_u              mst_w_data_o;
  mst_strb_t               mst_w_strb_o;
  logic                    mst_w_last_o;
  logic                    slv_err_o;
  logic                    busy_o;

  // One burst table row per test
  string  t_name  [NumTests] = '{"incr_aligned", "incr_unaligned", "incr_bytes",
                                 "incr_nomod", "wrap_error", "fixed_single"};
  logic [AddrWidth-1:0] t_addr [NumTests] = '{32'h100, 32'h104, 32'h200,
                                              32'h304, 32'h400, 32'h500};
  len_t   t_len   [NumTests] = '{8'd3, 8'd2, 8'd7, 8'd2, 8'd3, 8'd0};
  size_t  t_size  [NumTests] = '{3'd2, 3'd2, 3'd0, 3'd2, 3'd2, 3'd2};
  burst_e t_burst [NumTests] = '{BURST_INCR, BURST_INCR, BURST_INCR,
                                 BURST_INCR, BURST_WRAP, BURST_FIXED};
  cache_t t_cache [NumTests] = '{4'h2, 4'h2, 4'h3, 4'h0, 4'h2, 4'h2};
  // Idle cycles before each data beat
  int     t_gap   [NumTests] = '{0, 1, 0, 2, 0, 1};

  logic [SlvDataWidth-1:0] beat_data [256];
  logic [SlvStrbWidth-1:0] beat_strb [256];
  int                      beat_cycle [256];
  mode_e                   exp_mode;
  wide_word_u              exp_data_q [$];
  mst_strb_t               exp_strb_q [$];
  logic                    exp_last_q [$];
  // Slave beat that completes each expected wide beat
  int                      exp_src_q  [$];

  // Filled by the monitor
  wide_word_u           got_data_q [$];
  mst_strb_t            got_strb_q [$];
  logic                 got_last_q [$];
  int                   got_cycle_q [$];
  int                   aw_count;
  int                   err_count;
  int                   resp_cycle;
  logic [AddrWidth-1:0] got_aw_addr;
  len_t                 got_aw_len;
  size_t                got_aw_size;
  burst_e               got_aw_burst;

  int   cycle_cnt = 0;
  int   err_cnt = 0;
  int   bad_tests = 0;
  logic test_bad;

  dwc_upsizer_top #(
    .AddrWidth(AddrWidth)
  ) dwc_upsizer_top_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slv_aw_valid_i(slv_aw_valid_i),
    .slv_aw_addr_i (slv_aw_addr_i),
    .slv_aw_len_i  (slv_aw_len_i),
    .slv_aw_size_i (slv_aw_size_i),
    .slv_aw_burst_i(slv_aw_burst_i),
    .slv_aw_cache_i(slv_aw_cache_i),
    .slv_w_valid_i (slv_w_valid_i),
    .slv_w_data_i  (slv_w_data_i),
    .slv_w_strb_i  (slv_w_strb_i),
    .mst_aw_valid_o(mst_aw_valid_o),
    .mst_aw_addr_o (mst_aw_addr_o),
    .mst_aw_len_o  (mst_aw_len_o),
    .mst_aw_size_o (mst_aw_size_o),
    .mst_aw_burst_o(mst_aw_burst_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_data_o  (mst_w_data_o),
    .mst_w_strb_o  (mst_w_strb_o),
    .mst_w_last_o  (mst_w_last_o),
    .slv_err_o     (slv_err_o),
    .busy_o        (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk_i);
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("Simulation FAILED");
    $finish;
  end

  // Outputs are sampled mid-cycle away from the driving edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (mst_aw_valid_o) begin
        aw_count     = aw_count + 1;
        resp_cycle   = cycle_cnt;
        got_aw_addr  = mst_aw_addr_o;
        got_aw_len   = mst_aw_len_o;
        got_aw_size  = mst_aw_size_o;
        got_aw_burst = mst_aw_burst_o;
      end
      if (slv_err_o) begin
        err_count  = err_count + 1;
        resp_cycle = cycle_cnt;
      end
      if (mst_w_valid_o) begin
        got_data_q.push_back(mst_w_data_o);
        got_strb_q.push_back(mst_w_strb_o);
        got_last_q.push_back(mst_w_last_o);
        got_cycle_q.push_back(cycle_cnt);
      end
    end
  end

  task automatic record_error();
    err_cnt  = err_cnt + 1;
    test_bad = 1'b1;
  endtask

  task automatic check_aw(input string name,
                          input logic [AddrWidth-1:0] exp_addr, input len_t exp_len,
                          input size_t exp_size, input burst_e exp_burst,
                          input logic [AddrWidth-1:0] act_addr, input len_t act_len,
                          input size_t act_size, input burst_e act_burst);
    if ({exp_addr, exp_len, exp_size, exp_burst} !==
        {act_addr, act_len, act_size, act_burst}) begin
      $display("[FAIL] %s aw addr/len/size/burst: expected %h/%0d/%0d/%s actual %h/%0d/%0d/%s",
               name, exp_addr, exp_len, exp_size, exp_burst.name(),
               act_addr, act_len, act_size, act_burst.name());
      record_error();
    end
  endtask

  task automatic check_w(input string name, input int idx,
                         input wide_word_u exp_data, input mst_strb_t exp_strb,
                         input logic exp_last, input wide_word_u act_data,
                         input mst_strb_t act_strb, input logic act_last);
    if ({exp_data, exp_strb, exp_last} !== {act_data, act_strb, act_last}) begin
      $display("[FAIL] %s w beat %0d data/strb/last: expected %h/%h/%b actual %h/%h/%b",
               name, idx, exp_data, exp_strb, exp_last, act_data, act_strb, act_last);
      record_error();
    end
  endtask

  task automatic check_err(input string name, input logic exp_err, input logic act_err);
    if (exp_err !== act_err) begin
      $display("[FAIL] %s slv_err: expected %b actual %b", name, exp_err, act_err);
      record_error();
    end
  endtask

  task automatic check_count(input string name, input string what, input int exp_n,
                             input int act_n);
    if (exp_n != act_n) begin
      $display("[FAIL] %s %s count: expected %0d actual %0d", name, what, exp_n, act_n);
      record_error();
    end
  endtask

  function automatic mode_e expected_mode(input burst_e burst, input cache_t cache,
                                          input len_t len);
    if (burst == BURST_INCR) begin
      return (cache[CacheModifiable] && len != 0) ? MODE_UPSIZE : MODE_PASS;
    end
    return (len == 0) ? MODE_PASS : MODE_ERROR;
  endfunction

  // Byte-lane model where every narrow byte lands on wide lane addr[2:0]
  task automatic build_expected(input int row);
    int unsigned          bytes;
    logic [AddrWidth-1:0] aligned;
    logic [AddrWidth-1:0] baddr;
    logic [AddrWidth-1:0] next;
    logic [AddrWidth-1:0] a;
    wide_word_u           acc;
    mst_strb_t            acc_strb;
    bytes   = 1 << t_size[row];
    aligned = t_addr[row] & ~(AddrWidth'(bytes) - 1);
    acc      = '0;
    acc_strb = '0;
    exp_data_q.delete();
    exp_strb_q.delete();
    exp_last_q.delete();
    exp_src_q.delete();
    for (int i = 0; i <= int'(t_len[row]); i++) begin
      baddr        = (i == 0) ? t_addr[row] : aligned + i * bytes;
      next         = aligned + (i + 1) * bytes;
      beat_strb[i] = '0;
      for (int unsigned k = 0; k < bytes; k++) begin
        a = baddr + k;
        if (a < next) begin
          acc.bytes[a[2:0]]    = beat_data[i][8 * a[1:0] +: 8];
          acc_strb[a[2:0]]     = 1'b1;
          beat_strb[i][a[1:0]] = 1'b1;
        end
      end
      if (exp_mode == MODE_PASS || (exp_mode == MODE_UPSIZE &&
          ((next >> 3) != (baddr >> 3) || i == int'(t_len[row])))) begin
        exp_data_q.push_back(acc);
        exp_strb_q.push_back(acc_strb);
        exp_last_q.push_back(i == int'(t_len[row]));
        exp_src_q.push_back(i);
        acc      = '0;
        acc_strb = '0;
      end
    end
  endtask

  task automatic run_test(input int row);
    int     issue_cycle;
    int     n;
    len_t   exp_len;
    size_t  exp_size;
    string  name;
    name     = t_name[row];
    test_bad = 1'b0;
    for (int i = 0; i <= int'(t_len[row]); i++) begin
      beat_data[i] = $urandom();
    end
    exp_mode = expected_mode(t_burst[row], t_cache[row], t_len[row]);
    build_expected(row);

    @(posedge clk_i);
    #1;
    aw_count  = 0;
    err_count = 0;
    got_data_q.delete();
    got_strb_q.delete();
    got_last_q.delete();
    got_cycle_q.delete();
    slv_aw_valid_i = 1'b1;
    slv_aw_addr_i  = t_addr[row];
    slv_aw_len_i   = t_len[row];
    slv_aw_size_i  = t_size[row];
    slv_aw_burst_i = t_burst[row];
    slv_aw_cache_i = t_cache[row];
    issue_cycle    = cycle_cnt;

    for (int i = 0; i <= int'(t_len[row]); i++) begin
      for (int g = 0; g <= t_gap[row]; g++) begin
        @(posedge clk_i);
        #1;
        slv_aw_valid_i = 1'b0;
        slv_w_valid_i  = 1'b0;
      end
      slv_w_valid_i = 1'b1;
      slv_w_data_i  = beat_data[i];
      slv_w_strb_i  = beat_strb[i];
      beat_cycle[i] = cycle_cnt;
      @(negedge clk_i);
      if (!busy_o) begin
        $display("%s: busy_o was low while data beat %0d was sent", name, i);
        record_error();
      end
    end
    @(posedge clk_i);
    #1;
    slv_w_valid_i = 1'b0;
    // The burst is done once busy_o drops
    do @(negedge clk_i); while (busy_o);

    check_count(name, "master aw", (exp_mode == MODE_ERROR) ? 0 : 1, aw_count);
    check_err(name, exp_mode == MODE_ERROR, err_count != 0);
    if (resp_cycle != issue_cycle + 1) begin
      $display("%s: address response came %0d cycles after the slave address",
               name, resp_cycle - issue_cycle);
      record_error();
    end
    if (exp_mode != MODE_ERROR && aw_count == 1) begin
      exp_len  = (exp_mode == MODE_UPSIZE) ? len_t'(exp_data_q.size() - 1) : t_len[row];
      exp_size = (exp_mode == MODE_UPSIZE) ? size_t'(MstMaxSize) : t_size[row];
      check_aw(name, t_addr[row], exp_len, exp_size, t_burst[row],
               got_aw_addr, got_aw_len, got_aw_size, got_aw_burst);
    end
    check_count(name, "wide beat", exp_data_q.size(), got_data_q.size());
    n = (exp_data_q.size() < got_data_q.size()) ? exp_data_q.size() : got_data_q.size();
    for (int j = 0; j < n; j++) begin
      check_w(name, j, exp_data_q[j], exp_strb_q[j], exp_last_q[j],
              got_data_q[j], got_strb_q[j], got_last_q[j]);
      if (got_cycle_q[j] != beat_cycle[exp_src_q[j]] + 1) begin
        $display("%s: wide beat %0d came %0d cycles after its slave beat",
                 name, j, got_cycle_q[j] - beat_cycle[exp_src_q[j]]);
        record_error();
      end
    end
    if (test_bad) begin
      bad_tests = bad_tests + 1;
      $display("Test %s: mismatches found", name);
    end else begin
      $display("Test %s: ok", name);
    end
  endtask

  initial begin
    rst_ni         = 1'b0;
    slv_aw_valid_i = 1'b0;
    slv_aw_addr_i  = '0;
    slv_aw_len_i   = '0;
    slv_aw_size_i  = '0;
    slv_aw_burst_i = BURST_INCR;
    slv_aw_cache_i = '0;
    slv_w_valid_i  = 1'b0;
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    aw_count       = 0;
    err_count      = 0;
    resp_cycle     = 0;
    void'($urandom(32'h1924));
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int row = 0; row < NumTests; row++) begin
      run_test(row);
    end
    $display("Tests run %0d, failing tests %0d, failed checks %0d",
             NumTests, bad_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* dwc_upsizer.f */
hw/dwc_pkg.sv
hw/dwc_aw_decode.sv
hw/dwc_w_packer.sv
hw/dwc_upsizer_top.sv
dv/dwc_upsizer_asserts.sv
dv/dwc_upsizer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the upsizer testbench with Verilator.
# Exits 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=dwc_upsizer_sim

verilator --binary --timing --assert -Wno-fatal \
  --top-module dwc_upsizer_tb -f dwc_upsizer.f -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator compile step returned an error"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation binary exited with status $run_status"
  exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
  exit 0
fi
exit 1
